// ==== design/regex_macros.svh ====
`ifndef REGEX_MACROS_SVH
`define REGEX_MACROS_SVH

// Width of one character of the byte stream
`define REGEX_CHAR_W 8

// Width of a saved DFA state word
`define REGEX_STATE_W 11

// Width of the match counter
`define REGEX_COUNT_W 16

// Number of multiplexed flows and the id width that addresses them
`define REGEX_NUM_STREAMS 64
`define REGEX_SID_W 6

// Framer delays in clock cycles
// Characters line up with the restore latency of the context block
`define REGEX_CHAR_DLY 2
// End of packet waits until the last match flag has settled
`define REGEX_EOP_DLY 5

`endif

// ==== design/regex_pkg.sv ====
`include "regex_macros.svh"

package regex_pkg;

  // One byte of the stream
  typedef logic [`REGEX_CHAR_W-1:0] char_t;

  // Saved DFA state as kept in the per-stream memory
  typedef logic [`REGEX_STATE_W-1:0] dfa_state_t;

  // Matched packet counter
  typedef logic [`REGEX_COUNT_W-1:0] count_t;

  // Stream id
  typedef logic [`REGEX_SID_W-1:0] sid_t;

  // Keyword DFA states
  // ST_START must stay at zero since a new stream restores an all-zero state
  typedef enum dfa_state_t {
    ST_START = 11'd0,
    ST_U     = 11'd1,
    ST_US    = 11'd2,
    ST_USE   = 11'd3,
    ST_USER  = 11'd4,
    ST_P     = 11'd5,
    ST_PA    = 11'd6,
    ST_PAS   = 11'd7,
    ST_PASS  = 11'd8
  } dfa_state_e;

  // Framer phase
  typedef enum logic {
    PH_IDLE,
    PH_IN_PKT
  } frame_phase_e;

endpackage

// ==== design/pkt_framer.sv ====
`timescale 1ns/1ps

`include "regex_macros.svh"

module pkt_framer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              byte_vld,
  input  regex_pkg::char_t  byte_in,
  input  logic              pkt_sop,
  input  logic              pkt_eop,
  input  regex_pkg::sid_t   pkt_stream_id,
  input  logic              pkt_enable,
  output logic              load_state,
  output logic              new_stream_id,
  output regex_pkg::sid_t   stream_id,
  output logic              enable,
  output regex_pkg::char_t  char_in,
  output logic              char_in_vld,
  output logic              eop
);

  // Packet open or not
  regex_pkg::frame_phase_e phase;

  // One bit per stream id, set at the first sop of that stream
  logic [`REGEX_NUM_STREAMS-1:0] seen_q;

  // Delay lines for characters and end of packet
  regex_pkg::char_t char_pipe [`REGEX_CHAR_DLY];
  logic [`REGEX_CHAR_DLY-1:0] vld_pipe;
  logic [`REGEX_EOP_DLY-1:0]  eop_pipe;

  logic sop_acc;
  logic byte_acc;
  logic eop_acc;

  // A sop always comes with the first byte
  assign sop_acc  = byte_vld && pkt_sop;
  // Bytes outside an open packet are dropped
  assign byte_acc = byte_vld && (pkt_sop || (phase == regex_pkg::PH_IN_PKT));
  assign eop_acc  = byte_acc && pkt_eop;

  // Phase tracking and per-packet tags
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      phase         <= regex_pkg::PH_IDLE;
      seen_q        <= '0;
      load_state    <= 1'b0;
      new_stream_id <= 1'b0;
      enable        <= 1'b0;
    end
    else
    begin
      // Restore request one cycle after sop
      load_state <= sop_acc;
      if (sop_acc)
      begin
        // Single byte packet closes in the same cycle
        phase                  <= pkt_eop ? regex_pkg::PH_IDLE : regex_pkg::PH_IN_PKT;
        new_stream_id          <= ~seen_q[pkt_stream_id];
        seen_q[pkt_stream_id]  <= 1'b1;
        enable                 <= pkt_enable;
      end
      else if (eop_acc)
      begin
        phase <= regex_pkg::PH_IDLE;
      end
    end
  end

  // Stream id held from sop until the next sop
  always_ff @(posedge clk)
  begin
    if (sop_acc)
    begin
      stream_id <= pkt_stream_id;
    end
  end

  // Character payload delay
  always_ff @(posedge clk)
  begin
    char_pipe[0] <= byte_in;
    for (int i = 1; i < `REGEX_CHAR_DLY; i++)
    begin
      char_pipe[i] <= char_pipe[i-1];
    end
  end

  // Valid and eop strobes through their own shift registers
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      vld_pipe <= '0;
      eop_pipe <= '0;
    end
    else
    begin
      vld_pipe <= {vld_pipe[`REGEX_CHAR_DLY-2:0], byte_acc};
      eop_pipe <= {eop_pipe[`REGEX_EOP_DLY-2:0], eop_acc};
    end
  end

  assign char_in     = char_pipe[`REGEX_CHAR_DLY-1];
  assign char_in_vld = vld_pipe[`REGEX_CHAR_DLY-1];
  assign eop         = eop_pipe[`REGEX_EOP_DLY-1];

endmodule

// ==== design/stream_match_ctx.sv ====
`timescale 1ns/1ps

`include "regex_macros.svh"

module stream_match_ctx (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   eop,
  input  logic                   load_state,
  input  regex_pkg::char_t       char_in,
  input  logic                   enable,
  input  logic                   char_in_vld,
  input  regex_pkg::sid_t        stream_id,
  input  logic                   new_stream_id,
  output regex_pkg::count_t      count,
  output logic                   fired,
  // DFA side
  output regex_pkg::dfa_state_t  state_in,
  output logic                   state_in_vld,
  output regex_pkg::char_t       char_out,
  output logic                   char_out_vld,
  input  regex_pkg::dfa_state_t  state_out,
  input  logic                   accept_out
);

  // Saved DFA state per stream id
  regex_pkg::dfa_state_t state_mem [`REGEX_NUM_STREAMS];

  // First stage of the restore path
  regex_pkg::dfa_state_t restore_state;
  logic                  restore_vld;

  // Registered DFA outputs
  regex_pkg::dfa_state_t state_out_r;
  logic                  accept_out_r;

  // Per-packet match flag
  logic match_flag;
  // Includes an accept that lands in the eop cycle
  logic match_now;
  // Current packet is the first one of its stream
  logic pkt_is_new;

  assign match_now = match_flag | accept_out_r;
  assign fired     = match_flag;

  // Count, flag and new-packet tracking
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count      <= '0;
      match_flag <= 1'b0;
      pkt_is_new <= 1'b0;
    end
    else
    begin
      // Fresh flag for every packet
      if (load_state)
      begin
        match_flag <= 1'b0;
        pkt_is_new <= new_stream_id;
      end
      if (accept_out_r)
      begin
        match_flag <= 1'b1;
      end
      // Finalize at end of packet
      if (eop)
      begin
        if (enable)
        begin
          count <= count + regex_pkg::count_t'(match_now);
        end
        else
        begin
          // Disabled packet leaves no trace in fired
          match_flag <= 1'b0;
        end
      end
    end
  end

  // State save at end of packet
  always_ff @(posedge clk)
  begin
    if (eop)
    begin
      if (enable)
      begin
        state_mem[stream_id] <= state_out_r;
      end
      else if (pkt_is_new)
      begin
        // Stream first seen on a disabled packet still starts clean later
        state_mem[stream_id] <= regex_pkg::ST_START;
      end
    end
  end

  // Restore on load_state, zero for a stream never seen before
  always_ff @(posedge clk)
  begin
    if (load_state)
    begin
      restore_state <= new_stream_id ? regex_pkg::ST_START : state_mem[stream_id];
    end
  end

  // Control strobes towards the DFA
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      restore_vld  <= 1'b0;
      state_in_vld <= 1'b0;
      char_out_vld <= 1'b0;
      accept_out_r <= 1'b0;
    end
    else
    begin
      restore_vld  <= load_state;
      state_in_vld <= restore_vld;
      char_out_vld <= char_in_vld;
      accept_out_r <= accept_out;
    end
  end

  // Timing registers on the DFA data paths
  always_ff @(posedge clk)
  begin
    state_in    <= restore_state;
    char_out    <= char_in;
    state_out_r <= state_out;
  end

endmodule

// ==== design/pop3_dfa.sv ====
`timescale 1ns/1ps

module pop3_dfa (
  input  logic                   clk,
  input  logic                   rst_n,
  input  regex_pkg::char_t       char_in,
  input  logic                   char_in_vld,
  input  regex_pkg::dfa_state_t  state_in,
  input  logic                   state_in_vld,
  output regex_pkg::dfa_state_t  state_out,
  output logic                   accept_out
);

  // Keyword characters, upper case only
  localparam regex_pkg::char_t CH_U     = 8'h55;
  localparam regex_pkg::char_t CH_S     = 8'h53;
  localparam regex_pkg::char_t CH_E     = 8'h45;
  localparam regex_pkg::char_t CH_R     = 8'h52;
  localparam regex_pkg::char_t CH_P     = 8'h50;
  localparam regex_pkg::char_t CH_A     = 8'h41;
  localparam regex_pkg::char_t CH_SPACE = 8'h20;

  regex_pkg::dfa_state_e state_q;
  // State the current character is applied to
  regex_pkg::dfa_state_e base_state;
  regex_pkg::dfa_state_e step_state;
  logic                  accept_hit;

  // Mismatch target, a U or P may open a new keyword
  function automatic regex_pkg::dfa_state_e restart(input regex_pkg::char_t c);
    if (c == CH_U)
    begin
      return regex_pkg::ST_U;
    end
    else if (c == CH_P)
    begin
      return regex_pkg::ST_P;
    end
    return regex_pkg::ST_START;
  endfunction

  // One DFA transition
  function automatic regex_pkg::dfa_state_e step(input regex_pkg::dfa_state_e s,
                                                 input regex_pkg::char_t c);
    regex_pkg::dfa_state_e nxt;
    nxt = restart(c);
    case (s)
      regex_pkg::ST_U:    if (c == CH_S) nxt = regex_pkg::ST_US;
      regex_pkg::ST_US:   if (c == CH_E) nxt = regex_pkg::ST_USE;
      regex_pkg::ST_USE:  if (c == CH_R) nxt = regex_pkg::ST_USER;
      regex_pkg::ST_P:    if (c == CH_A) nxt = regex_pkg::ST_PA;
      regex_pkg::ST_PA:   if (c == CH_S) nxt = regex_pkg::ST_PAS;
      regex_pkg::ST_PAS:  if (c == CH_S) nxt = regex_pkg::ST_PASS;
      // Space after a full keyword is the match, then back to start
      regex_pkg::ST_USER,
      regex_pkg::ST_PASS: if (c == CH_SPACE) nxt = regex_pkg::ST_START;
      default:            nxt = restart(c);
    endcase
    return nxt;
  endfunction

  // Restored state takes over in the cycle it arrives
  // The first character of a packet comes in the same cycle
  always_comb
  begin
    base_state = state_in_vld ? regex_pkg::dfa_state_e'(state_in) : state_q;
    step_state = step(base_state, char_in);
    accept_hit = char_in_vld && (char_in == CH_SPACE) &&
                 ((base_state == regex_pkg::ST_USER) || (base_state == regex_pkg::ST_PASS));
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q    <= regex_pkg::ST_START;
      accept_out <= 1'b0;
    end
    else
    begin
      // One-cycle pulse per completed keyword
      accept_out <= accept_hit;
      if (char_in_vld)
      begin
        state_q <= step_state;
      end
      else if (state_in_vld)
      begin
        state_q <= base_state;
      end
    end
  end

  assign state_out = state_q;

endmodule

// ==== design/regex_match_top.sv ====
`timescale 1ns/1ps

module regex_match_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               byte_vld,
  input  regex_pkg::char_t   byte_in,
  input  logic               pkt_sop,
  input  logic               pkt_eop,
  input  regex_pkg::sid_t    pkt_stream_id,
  input  logic               pkt_enable,
  output regex_pkg::count_t  count,
  output logic               fired
);

  // Framer to context
  logic                  load_state;
  logic                  new_stream_id;
  regex_pkg::sid_t       stream_id;
  logic                  enable;
  regex_pkg::char_t      char_in;
  logic                  char_in_vld;
  logic                  eop;

  // Context and DFA
  regex_pkg::char_t      dfa_char;
  logic                  dfa_char_vld;
  regex_pkg::dfa_state_t dfa_state_in;
  logic                  dfa_state_in_vld;
  regex_pkg::dfa_state_t dfa_state_out;
  logic                  dfa_accept;

  pkt_framer u_framer (
    .clk           (clk),
    .rst_n         (rst_n),
    .byte_vld      (byte_vld),
    .byte_in       (byte_in),
    .pkt_sop       (pkt_sop),
    .pkt_eop       (pkt_eop),
    .pkt_stream_id (pkt_stream_id),
    .pkt_enable    (pkt_enable),
    .load_state    (load_state),
    .new_stream_id (new_stream_id),
    .stream_id     (stream_id),
    .enable        (enable),
    .char_in       (char_in),
    .char_in_vld   (char_in_vld),
    .eop           (eop)
  );

  stream_match_ctx u_ctx (
    .clk           (clk),
    .rst_n         (rst_n),
    .eop           (eop),
    .load_state    (load_state),
    .char_in       (char_in),
    .enable        (enable),
    .char_in_vld   (char_in_vld),
    .stream_id     (stream_id),
    .new_stream_id (new_stream_id),
    .count         (count),
    .fired         (fired),
    .state_in      (dfa_state_in),
    .state_in_vld  (dfa_state_in_vld),
    .char_out      (dfa_char),
    .char_out_vld  (dfa_char_vld),
    .state_out     (dfa_state_out),
    .accept_out    (dfa_accept)
  );

  pop3_dfa u_dfa (
    .clk          (clk),
    .rst_n        (rst_n),
    .char_in      (dfa_char),
    .char_in_vld  (dfa_char_vld),
    .state_in     (dfa_state_in),
    .state_in_vld (dfa_state_in_vld),
    .state_out    (dfa_state_out),
    .accept_out   (dfa_accept)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  // Free running clock
  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset low for the first edges, released on a falling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== verification/tb_regex_match.sv ====
`timescale 1ns/1ps

`include "regex_macros.svh"

module tb_regex_match;

  localparam int          DRIVE_DLY     = 2;
  localparam int          MAX_PKT_BYTES = 32;
  localparam int          MAX_LINES     = 256;
  localparam int          RESET_TIMEOUT = 100;
  localparam int          IDLE_TIMEOUT  = 64;
  // Input eop to updated count
  localparam int          SETTLE_CYCLES = `REGEX_EOP_DLY + 1;
  localparam logic [31:0] LCG_SEED      = 32'hc545_bb5f;

  logic                clk;
  logic                rst_n;
  logic                byte_vld;
  regex_pkg::char_t    byte_in;
  logic                pkt_sop;
  logic                pkt_eop;
  regex_pkg::sid_t     pkt_stream_id;
  logic                pkt_enable;
  regex_pkg::count_t   count;
  logic                fired;

  // Run bookkeeping
  int                  fd;
  int                  record_count;
  logic [31:0]         lcg_state;
  // Bytes of the packet being sent
  regex_pkg::char_t    pkt_bytes[$];

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(10)) u_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  regex_match_top dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .byte_vld      (byte_vld),
    .byte_in       (byte_in),
    .pkt_sop       (pkt_sop),
    .pkt_eop       (pkt_eop),
    .pkt_stream_id (pkt_stream_id),
    .pkt_enable    (pkt_enable),
    .count         (count),
    .fired         (fired)
  );

  // Classic 32-bit LCG step
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_on_failure();
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_count(input regex_pkg::count_t expected,
                             input regex_pkg::count_t actual, input int record);
    if (actual !== expected)
    begin
      $display("error: time %0t, count expected %0d actual %0d (record %0d)",
               $time, expected, actual, record);
      stop_on_failure();
    end
  endtask

  task automatic check_fired(input logic expected, input logic actual, input int record);
    if (actual !== expected)
    begin
      $display("error: time %0t, fired expected %0b actual %0b (record %0d)",
               $time, expected, actual, record);
      stop_on_failure();
    end
  endtask

  // Quiet bus between packets
  task automatic drive_idle();
    byte_vld      = 1'b0;
    byte_in       = '0;
    pkt_sop       = 1'b0;
    pkt_eop       = 1'b0;
    pkt_stream_id = '0;
    pkt_enable    = 1'b0;
  endtask

  // Step n edges and land DRIVE_DLY after each
  task automatic idle_cycles(input int n);
    int waited;
    waited = 0;
    while (waited < n)
    begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
      if (waited > IDLE_TIMEOUT)
      begin
        $display("error: idle wait of %0d cycles ran past its limit", n);
        stop_on_failure();
      end
    end
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (rst_n !== 1'b1)
    begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
      if (waited > RESET_TIMEOUT)
      begin
        $display("error: reset was still active after %0d cycles", RESET_TIMEOUT);
        stop_on_failure();
      end
    end
    // DUT has seen rst_n high at least once here
    idle_cycles(1);
  endtask

  // Unpack a %s token where an underscore stands for a space
  task automatic text_to_bytes(input logic [`REGEX_CHAR_W*MAX_PKT_BYTES-1:0] text);
    regex_pkg::char_t c;
    int               i;
    pkt_bytes.delete();
    for (i = MAX_PKT_BYTES - 1; i >= 0; i--)
    begin
      c = text[i*`REGEX_CHAR_W +: `REGEX_CHAR_W];
      // Leading zero bytes are padding of the packed token
      if (c != 8'h00)
      begin
        pkt_bytes.push_back((c == 8'h5f) ? 8'h20 : c);
      end
    end
  endtask

  // One byte per cycle with sop on the first and eop on the last
  task automatic drive_packet(input regex_pkg::sid_t sid, input logic en);
    int i;
    for (i = 0; i < pkt_bytes.size(); i++)
    begin
      byte_vld      = 1'b1;
      byte_in       = pkt_bytes[i];
      pkt_sop       = (i == 0);
      pkt_eop       = (i == pkt_bytes.size() - 1);
      pkt_stream_id = sid;
      pkt_enable    = en;
      @(posedge clk);
      #DRIVE_DLY;
    end
    drive_idle();
  endtask

  task automatic run_golden_file();
    string                                    line;
    int                                       status;
    int                                       fields;
    int                                       lines_read;
    int                                       extra;
    regex_pkg::sid_t                          sid;
    logic                                     en;
    logic                                     exp_fired;
    regex_pkg::count_t                        exp_count;
    logic [`REGEX_CHAR_W*MAX_PKT_BYTES-1:0]   text;
    lines_read = 0;
    while (!$feof(fd) && (lines_read < MAX_LINES))
    begin
      status = $fgets(line, fd);
      lines_read++;
      // Skip comments and empty lines
      if ((status > 0) && (line.len() > 1) && (line.getc(0) != 8'h23))
      begin
        text   = '0;
        fields = $sscanf(line, "%h %h %s %h %h", sid, en, text, exp_fired, exp_count);
        if (fields != 5)
        begin
          $display("error: golden file line %0d does not hold five fields", lines_read);
          stop_on_failure();
        end
        record_count++;
        text_to_bytes(text);
        drive_packet(sid, en);
        // Count and fired are final once eop has gone through the pipe
        idle_cycles(SETTLE_CYCLES);
        check_fired(exp_fired, fired, record_count);
        check_count(exp_count, count, record_count);
        // Extra idle time for a total gap of 6 to 12 cycles
        lcg_state = lcg_next(lcg_state);
        extra     = int'({16'd0, lcg_state[31:16]} % 32'd7);
        idle_cycles(extra);
      end
    end
    if (!$feof(fd))
    begin
      $display("error: golden file has more than %0d lines", MAX_LINES);
      stop_on_failure();
    end
  endtask

  initial
  begin
    drive_idle();
    record_count = 0;
    lcg_state    = LCG_SEED;

    wait_reset_release();
    // Outputs straight out of reset
    check_count('0, count, 0);
    check_fired(1'b0, fired, 0);

    fd = $fopen("verification/regex_golden.txt", "r");
    if (fd == 0)
    begin
      $display("error: the golden file verification/regex_golden.txt could not be opened");
      stop_on_failure();
    end
    run_golden_file();
    $fclose(fd);

    if (record_count == 0)
    begin
      $display("error: the golden file held no packet records");
      stop_on_failure();
    end

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+design
design/regex_pkg.sv
design/pkt_framer.sv
design/stream_match_ctx.sv
design/pop3_dfa.sv
design/regex_match_top.sv
verification/tb_clock_gen.sv
verification/tb_regex_match.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the regex match testbench with Verilator
# The result comes from the log, a fail line there means the run failed

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing -f src.f --top-module tb_regex_match > "$LOG" 2>&1 \
  || { echo "Verilator build failed, see $LOG"; exit 1; }

./obj_dir/Vtb_regex_match >> "$LOG" 2>&1

grep -q "Some tests failed" "$LOG" \
  && { echo "Simulation reported a failure, see $LOG"; exit 1; }

grep -q "All tests passed" "$LOG" \
  && { echo "Simulation finished cleanly"; exit 0; } \
  || { echo "Simulation ended without a result, see $LOG"; exit 1; }

// ==== verification/regex_golden.txt ====
# Columns: stream id (hex), enable, packet bytes, expected fired, expected count (hex)
# In the packet bytes an underscore stands for a space
# Single packets, one match per packet at most
00 1 USER_alice 1 0001
01 1 hello 0 0001
02 1 PASS_x_USER_y 1 0002
# Keyword split over two packets of stream 4
04 1 xxUS 0 0002
04 1 ER_bob 1 0003
# Stream 3 prefix, unrelated stream 9, then the rest on stream 3
03 1 PA 0 0003
09 1 USERNAME 0 0003
03 1 SS_me 1 0004
# Disabled packet neither counts nor saves its state
05 1 USE 0 0004
05 0 R_xyz 0 0004
05 1 R_ 1 0005
# Stream first seen on a disabled packet starts clean afterwards
06 0 PAS 0 0005
06 1 S_ 0 0005
# New stream starts from ST_START while stream 7 waits in ST_USER
07 1 USER 0 0005
08 1 _R_ 0 0005
07 1 _ 1 0006
# Restart on repeated first letters
3f 1 PPASS_ 1 0007
0a 1 user_ 0 0007
0b 1 UUSER_ 1 0008
00 1 USERUSER_ 1 0009
# Disabled middle packet between two parts of PASS
0c 1 PAS 0 0009
0c 0 S_ 0 0009
0c 1 S_ 1 000a
# Keyword without the trailing space
01 1 PASS 0 000a
01 1 word 0 000a
